//--- hw/jtag_bridge_pkg.sv
package jtag_bridge_pkg;

    // Opcodes in the low nibble of a shifted command word
    typedef enum logic [3:0] {
        OP_ADDR = 4'd1,
        OP_BE   = 4'd2,
        OP_SIZE = 4'd3,
        OP_DATA = 4'd8,
        OP_READ = 4'd9,
        OP_ACK  = 4'd10
    } chain_op_e;

    // Bit positions inside the 6-bit status word
    localparam int ST_ADDR  = 0;
    localparam int ST_BE    = 1;
    localparam int ST_SIZE  = 2;
    localparam int ST_WRITE = 3;
    localparam int ST_READ  = 4;
    localparam int ST_RDY   = 5;

    localparam int BUF_DEPTH_DEF = 16;
    localparam int MEM_WORDS_DEF = 64;

    // Buffer word index, sized for the largest bank
    localparam int PP_IDX_W = 4;

    typedef struct packed {
        logic [31:0] payload;
        logic [3:0]  op;
    } cmd_view_t;

    typedef struct packed {
        logic [2:0]  marker;
        logic        more;
        logic [31:0] data;
    } rb_view_t;

    // Same 36 bits, read as a command at update or built as readback at capture
    typedef union packed {
        cmd_view_t cmd;
        rb_view_t  rb;
    } shift_word_u;

    typedef struct packed {
        logic [PP_IDX_W-1:0] idx;
        logic                we;
        logic [31:0]         wdata;
    } pp_req_t;

    typedef struct packed {
        logic        wr;
        logic        rd;
        logic [31:0] addr;
        logic [3:0]  be;
        logic [7:0]  last;
    } dma_cmd_t;

endpackage

//--- hw/jtag_chain.sv
`timescale 1ns/1ps

module jtag_chain import jtag_bridge_pkg::*; #(
    parameter int BUF_DEPTH = BUF_DEPTH_DEF
) (
    input  logic        JTCK,
    input  logic        JRSTN,
    input  logic        JTDI,
    input  logic        JSHIFT,
    input  logic        JUPDATE,
    input  logic        JCE1,
    output logic        JTD1,
    output pp_req_t     chain_req,
    input  logic [31:0] chain_rdata,
    output logic        pp_switch,
    output dma_cmd_t    dma_cmd,
    input  logic        dma_busy
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_W_FILL,
        S_W_WAIT,
        S_W_SWITCH,
        S_W_LAUNCH,
        S_R_LAUNCH,
        S_R_WAIT,
        S_R_SWITCH,
        S_R_ASK,
        S_R_STORE,
        S_R_READY
    } state_e;

    state_e              state;
    shift_word_u         sr;
    shift_word_u         cap_word;
    logic [5:0]          status;
    logic [31:0]         addr_reg;
    logic [3:0]          be_reg;
    logic [7:0]          size_reg;
    logic [7:0]          remaining;
    logic [PP_IDX_W-1:0] word_idx;
    logic [PP_IDX_W-1:0] next_idx;
    logic [31:0]         data_reg;
    logic [31:0]         rd_word;
    logic                cfg_locked;
    logic                consume;

    assign JTD1       = sr[0];
    assign cfg_locked = status[ST_WRITE] | status[ST_READ];
    assign next_idx   = (word_idx == PP_IDX_W'(BUF_DEPTH - 1)) ? '0 : word_idx + 1'b1;

    // A capture with a word ready hands it out, so does an explicit ack
    assign consume = status[ST_RDY] &
                     ((JCE1 & ~JSHIFT) | (JUPDATE & (sr.cmd.op == OP_ACK)));

    always_comb begin
        cap_word = {30'b0, status};
        if (status[ST_RDY]) begin
            cap_word.rb.marker = 3'b111;
            cap_word.rb.more   = (remaining != 8'd0);
            cap_word.rb.data   = rd_word;
        end
    end

    always_ff @(posedge JTCK or negedge JRSTN) begin
        if (!JRSTN) begin
            sr        <= '0;
            status    <= '0;
            addr_reg  <= '0;
            be_reg    <= '0;
            size_reg  <= '0;
            remaining <= '0;
            word_idx  <= '0;
            state     <= S_IDLE;
        end else begin
            if (JCE1) begin
                if (JSHIFT) begin
                    sr <= {JTDI, sr[35:1]};
                end else begin
                    sr <= cap_word;
                end
            end

            if (JUPDATE) begin
                case (sr.cmd.op)
                    OP_ADDR: begin
                        if (!cfg_locked) begin
                            addr_reg        <= sr.cmd.payload;
                            status[ST_ADDR] <= 1'b1;
                        end
                    end
                    OP_BE: begin
                        if (!cfg_locked) begin
                            be_reg        <= sr.cmd.payload[3:0];
                            status[ST_BE] <= 1'b1;
                        end
                    end
                    OP_SIZE: begin
                        if (!cfg_locked) begin
                            size_reg        <= sr.cmd.payload[7:0];
                            remaining       <= sr.cmd.payload[7:0];
                            status[ST_SIZE] <= 1'b1;
                        end
                    end
                    OP_DATA: begin
                        if (state == S_IDLE && !status[ST_READ]) begin
                            status[ST_WRITE] <= 1'b1;
                            state            <= S_W_FILL;
                        end
                    end
                    OP_READ: begin
                        if (state == S_IDLE && !status[ST_WRITE]) begin
                            status[ST_READ] <= 1'b1;
                            state           <= S_R_LAUNCH;
                        end
                    end
                    default: ;
                endcase
            end

            case (state)
                S_W_FILL: begin
                    if (remaining == 8'd0) begin
                        state <= S_W_WAIT;
                    end else begin
                        remaining <= remaining - 8'd1;
                        word_idx  <= next_idx;
                        state     <= S_IDLE;
                    end
                end
                S_W_WAIT: begin
                    if (!dma_busy) begin
                        state <= S_W_SWITCH;
                    end
                end
                S_W_SWITCH: state <= S_W_LAUNCH;
                S_W_LAUNCH: begin
                    status[ST_WRITE] <= 1'b0;
                    remaining        <= size_reg;
                    word_idx         <= '0;
                    state            <= S_IDLE;
                end
                // Launch only once an earlier write copy has drained
                S_R_LAUNCH: begin
                    if (!dma_busy) begin
                        state <= S_R_WAIT;
                    end
                end
                S_R_WAIT: begin
                    if (!dma_busy) begin
                        state <= S_R_SWITCH;
                    end
                end
                S_R_SWITCH: state <= S_R_ASK;
                S_R_ASK:    state <= S_R_STORE;
                S_R_STORE: begin
                    status[ST_RDY] <= 1'b1;
                    state          <= S_R_READY;
                end
                S_R_READY: begin
                    if (consume) begin
                        status[ST_RDY] <= 1'b0;
                        if (remaining == 8'd0) begin
                            status[ST_READ] <= 1'b0;
                            remaining       <= size_reg;
                            word_idx        <= '0;
                            state           <= S_IDLE;
                        end else begin
                            remaining <= remaining - 8'd1;
                            word_idx  <= next_idx;
                            state     <= S_R_ASK;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge JTCK) begin
        if (JUPDATE && sr.cmd.op == OP_DATA) begin
            data_reg <= sr.cmd.payload;
        end
        if (state == S_R_STORE) begin
            rd_word <= chain_rdata;
        end
    end

    always_comb begin
        chain_req.idx   = word_idx;
        chain_req.we    = (state == S_W_FILL);
        chain_req.wdata = data_reg;
    end

    assign pp_switch = (state == S_W_SWITCH) | (state == S_R_SWITCH);

    always_comb begin
        dma_cmd.wr   = (state == S_W_LAUNCH);
        dma_cmd.rd   = (state == S_R_LAUNCH) & ~dma_busy;
        dma_cmd.addr = addr_reg;
        dma_cmd.be   = be_reg;
        dma_cmd.last = size_reg;
    end

endmodule

//--- hw/pingpong_buffer.sv
`timescale 1ns/1ps

module pingpong_buffer import jtag_bridge_pkg::*; #(
    parameter int BUF_DEPTH = BUF_DEPTH_DEF
) (
    input  logic        JTCK,
    input  logic        JRSTN,
    input  pp_req_t     chain_req,
    input  pp_req_t     dma_req,
    input  logic        pp_switch,
    output logic [31:0] chain_rdata,
    output logic [31:0] dma_rdata
);

    localparam int IDX_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;

    logic [31:0] bank [2][BUF_DEPTH];
    // Bank currently owned by the chain, the DMA owns the other
    logic        side;
    logic [IDX_W-1:0] chain_idx;
    logic [IDX_W-1:0] dma_idx;

    assign chain_idx = chain_req.idx[IDX_W-1:0];
    assign dma_idx   = dma_req.idx[IDX_W-1:0];

    always_ff @(posedge JTCK or negedge JRSTN) begin
        if (!JRSTN) begin
            side <= 1'b0;
        end else if (pp_switch) begin
            side <= ~side;
        end
    end

    always_ff @(posedge JTCK) begin
        if (chain_req.we) begin
            bank[side][chain_idx] <= chain_req.wdata;
        end
        if (dma_req.we) begin
            bank[~side][dma_idx] <= dma_req.wdata;
        end
        chain_rdata <= bank[side][chain_idx];
        dma_rdata   <= bank[~side][dma_idx];
    end

endmodule

//--- hw/dma_engine.sv
`timescale 1ns/1ps

module dma_engine import jtag_bridge_pkg::*; #(
    parameter int BUF_DEPTH = BUF_DEPTH_DEF,
    parameter int MEM_WORDS = MEM_WORDS_DEF
) (
    input  logic        JTCK,
    input  logic        JRSTN,
    input  dma_cmd_t    dma_cmd,
    input  logic [31:0] dma_rdata,
    output pp_req_t     dma_req,
    output logic        dma_busy
);

    localparam int MEM_AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    typedef enum logic [1:0] {
        D_IDLE,
        D_WR,
        D_RD
    } dstate_e;

    dstate_e     state;
    logic [31:0] mem [MEM_WORDS];
    logic [31:0] base;
    logic [3:0]  be;
    logic [7:0]  last;
    logic [7:0]  cnt;
    logic [7:0]  pend_cnt;
    logic        pend_v;
    logic        issue_done;

    // Word address wraps around the memory size
    function automatic logic [MEM_AW-1:0] mem_addr(input logic [7:0] c);
        logic [31:0] sum;
        sum = (base + 32'(c)) % 32'(MEM_WORDS);
        return sum[MEM_AW-1:0];
    endfunction

    assign dma_busy = (state != D_IDLE);

    always_comb begin
        dma_req.idx   = PP_IDX_W'(cnt % 8'(BUF_DEPTH));
        dma_req.we    = (state == D_RD);
        dma_req.wdata = mem[mem_addr(cnt)];
    end

    always_ff @(posedge JTCK or negedge JRSTN) begin
        if (!JRSTN) begin
            state      <= D_IDLE;
            base       <= '0;
            be         <= '0;
            last       <= '0;
            cnt        <= '0;
            pend_cnt   <= '0;
            pend_v     <= 1'b0;
            issue_done <= 1'b0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            case (state)
                D_IDLE: begin
                    cnt        <= '0;
                    pend_v     <= 1'b0;
                    issue_done <= 1'b0;
                    if (dma_cmd.wr || dma_cmd.rd) begin
                        base  <= dma_cmd.addr;
                        be    <= dma_cmd.be;
                        last  <= dma_cmd.last;
                        state <= dma_cmd.wr ? D_WR : D_RD;
                    end
                end
                // Bank read issued one cycle, merged into memory the next
                D_WR: begin
                    pend_v   <= ~issue_done;
                    pend_cnt <= cnt;
                    if (!issue_done) begin
                        if (cnt == last) begin
                            issue_done <= 1'b1;
                        end else begin
                            cnt <= cnt + 8'd1;
                        end
                    end
                    if (pend_v) begin
                        for (int b = 0; b < 4; b++) begin
                            if (be[b]) begin
                                mem[mem_addr(pend_cnt)][8*b +: 8] <= dma_rdata[8*b +: 8];
                            end
                        end
                        if (pend_cnt == last) begin
                            state <= D_IDLE;
                        end
                    end
                end
                D_RD: begin
                    if (cnt == last) begin
                        state <= D_IDLE;
                    end else begin
                        cnt <= cnt + 8'd1;
                    end
                end
                default: state <= D_IDLE;
            endcase
        end
    end

endmodule

//--- hw/jtag_dma_top.sv
`timescale 1ns/1ps

module jtag_dma_top import jtag_bridge_pkg::*; #(
    parameter int BUF_DEPTH = BUF_DEPTH_DEF,
    parameter int MEM_WORDS = MEM_WORDS_DEF
) (
    input  logic JTCK,
    input  logic JRSTN,
    input  logic JTDI,
    input  logic JSHIFT,
    input  logic JUPDATE,
    input  logic JCE1,
    output logic JTD1
);

    pp_req_t     chain_req;
    pp_req_t     dma_req;
    logic [31:0] chain_rdata;
    logic [31:0] dma_rdata;
    logic        pp_switch;
    dma_cmd_t    dma_cmd;
    logic        dma_busy;

    jtag_chain #(
        .BUF_DEPTH(BUF_DEPTH)
    ) u_chain (
        .JTCK       (JTCK),
        .JRSTN      (JRSTN),
        .JTDI       (JTDI),
        .JSHIFT     (JSHIFT),
        .JUPDATE    (JUPDATE),
        .JCE1       (JCE1),
        .JTD1       (JTD1),
        .chain_req  (chain_req),
        .chain_rdata(chain_rdata),
        .pp_switch  (pp_switch),
        .dma_cmd    (dma_cmd),
        .dma_busy   (dma_busy)
    );

    pingpong_buffer #(
        .BUF_DEPTH(BUF_DEPTH)
    ) u_buf (
        .JTCK       (JTCK),
        .JRSTN      (JRSTN),
        .chain_req  (chain_req),
        .dma_req    (dma_req),
        .pp_switch  (pp_switch),
        .chain_rdata(chain_rdata),
        .dma_rdata  (dma_rdata)
    );

    dma_engine #(
        .BUF_DEPTH(BUF_DEPTH),
        .MEM_WORDS(MEM_WORDS)
    ) u_dma (
        .JTCK     (JTCK),
        .JRSTN    (JRSTN),
        .dma_cmd  (dma_cmd),
        .dma_rdata(dma_rdata),
        .dma_req  (dma_req),
        .dma_busy (dma_busy)
    );

endmodule

//--- tb/tb_checker.sv
`timescale 1ns/1ps

module tb_checker import jtag_bridge_pkg::*; #(
    parameter int MEM_WORDS = MEM_WORDS_DEF
) (
    input logic JTCK,
    input logic JCE1,
    input logic JSHIFT,
    input logic JTD1
);

    localparam int AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    logic [31:0] shadow [MEM_WORDS] = '{default: 32'h0};
    logic [35:0] cap_bits;
    logic [5:0]  bit_cnt = 6'd36;
    shift_word_u last_word;
    string       test_name = "reset";
    int          errors = 0;
    int          checks = 0;

    // Rebuild each captured word from JTD1, one bit per shift edge
    always @(negedge JTCK) begin
        if (JCE1 && !JSHIFT) begin
            bit_cnt <= 6'd0;
        end else if (JCE1 && JSHIFT && bit_cnt < 6'd36) begin
            cap_bits <= {JTD1, cap_bits[35:1]};
            bit_cnt  <= bit_cnt + 6'd1;
            if (bit_cnt == 6'd35) begin
                last_word <= {JTD1, cap_bits[35:1]};
            end
        end
    end

    function automatic logic has_marker();
        return last_word.rb.marker != 3'b000;
    endfunction

    task automatic set_test(input string name);
        test_name = name;
    endtask

    // Same byte merge as the memory side of the bridge
    task automatic note_write(input logic [31:0] addr, input logic [3:0] be,
                              input logic [31:0] data);
        logic [AW-1:0] a;
        a = AW'(addr % 32'(MEM_WORDS));
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                shadow[a][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    task automatic check_status(input logic [5:0] exp);
        logic [35:0] got;
        got = last_word;
        checks++;
        if (got != {30'b0, exp}) begin
            errors++;
            $display("[FAIL] %s: status expected %h, actual %h", test_name,
                     {30'b0, exp}, got);
        end
    endtask

    task automatic check_readback(input logic [31:0] addr, input logic more);
        logic [AW-1:0] a;
        logic [31:0]   exp;
        a   = AW'(addr % 32'(MEM_WORDS));
        exp = shadow[a];
        checks++;
        if (last_word.rb.marker != 3'b111) begin
            errors++;
            $display("%s: readback marker is %b, it should be all ones", test_name,
                     last_word.rb.marker);
        end
        if (last_word.rb.more != more) begin
            errors++;
            $display("%s: more flag is %0d for word address %0d, it should be %0d",
                     test_name, last_word.rb.more, addr, more);
        end
        if (last_word.rb.data != exp) begin
            errors++;
            $display("[FAIL] %s: word %0d expected %h, actual %h", test_name, addr,
                     exp, last_word.rb.data);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("%s: %s", test_name, msg);
    endtask

endmodule

//--- tb/bridge_sva.sv
`timescale 1ns/1ps

module bridge_sva import jtag_bridge_pkg::*; (
    input logic     JTCK,
    input logic     JRSTN,
    input dma_cmd_t dma_cmd,
    input logic     dma_busy,
    input logic     pp_switch
);

    int fail_cnt = 0;

    launch_when_idle: assert property (@(posedge JTCK) disable iff (!JRSTN)
        (dma_cmd.wr || dma_cmd.rd) |-> !dma_busy)
        else begin
            fail_cnt++;
            $error("DMA launch while the DMA is still busy");
        end

    // Banks must not swap under a running copy
    switch_when_idle: assert property (@(posedge JTCK) disable iff (!JRSTN)
        pp_switch |-> !dma_busy)
        else begin
            fail_cnt++;
            $error("Buffer switch while the DMA is busy");
        end

    one_direction: assert property (@(posedge JTCK) disable iff (!JRSTN)
        !(dma_cmd.wr && dma_cmd.rd))
        else begin
            fail_cnt++;
            $error("Write and read launch in the same cycle");
        end

endmodule

bind jtag_chain bridge_sva i_sva (
    .JTCK     (JTCK),
    .JRSTN    (JRSTN),
    .dma_cmd  (dma_cmd),
    .dma_busy (dma_busy),
    .pp_switch(pp_switch)
);

//--- tb/tb_top.sv
`timescale 1ns/1ps

module tb_top import jtag_bridge_pkg::*; #(
    parameter int BUF_DEPTH = BUF_DEPTH_DEF,
    parameter int MEM_WORDS = MEM_WORDS_DEF
) ();

    localparam int RST_CYC   = 8;
    localparam int POLL_MAX  = 20;
    localparam int N_BURSTS  = 6;
    // Cycles for one shifted word and its update with some slack
    localparam int WORD_CYC  = 40;
    localparam int BURST_CYC = WORD_CYC * (8 + 6 * BUF_DEPTH);
    localparam int LIMIT_CYC = RST_CYC + N_BURSTS * BURST_CYC + 1000;
    localparam logic [5:0] CFG_STATUS = 6'((1 << ST_ADDR) | (1 << ST_BE) | (1 << ST_SIZE));

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  be;
        logic [7:0]  last;
        logic        decoy;
    } burst_t;

    logic JTCK;
    logic JRSTN;
    logic JTDI;
    logic JSHIFT;
    logic JUPDATE;
    logic JCE1;
    logic JTD1;
    int   seed;

    // Word address, byte enable, last index, address command sent mid-read
    burst_t bursts [N_BURSTS] = '{
        '{32'd5,  4'hf,    8'd0,  1'b0},
        '{32'd10, 4'hf,    8'd3,  1'b0},
        '{32'd10, 4'b0101, 8'd3,  1'b0},
        '{32'd62, 4'b1100, 8'd3,  1'b0},
        '{32'd30, 4'hf,    8'd15, 1'b0},
        '{32'd50, 4'hf,    8'd1,  1'b1}
    };
    string names [N_BURSTS] = '{
        "single_word", "burst_four", "partial_be", "wrap_end", "full_depth", "cfg_locked"
    };

    jtag_dma_top #(
        .BUF_DEPTH(BUF_DEPTH),
        .MEM_WORDS(MEM_WORDS)
    ) i_dut (
        .JTCK   (JTCK),
        .JRSTN  (JRSTN),
        .JTDI   (JTDI),
        .JSHIFT (JSHIFT),
        .JUPDATE(JUPDATE),
        .JCE1   (JCE1),
        .JTD1   (JTD1)
    );

    tb_checker #(
        .MEM_WORDS(MEM_WORDS)
    ) i_chk (
        .JTCK  (JTCK),
        .JCE1  (JCE1),
        .JSHIFT(JSHIFT),
        .JTD1  (JTD1)
    );

    initial begin
        JTCK = 1'b0;
        forever #50 JTCK = ~JTCK;
    end

    initial begin
        repeat (LIMIT_CYC) @(posedge JTCK);
        $display("Timeout: the run did not finish within %0d cycles", LIMIT_CYC);
        $display("TEST FAILED");
        $finish;
    end

    // Shift LSB first through JTDI and pulse JUPDATE after
    task automatic send_word(input logic [3:0] op, input logic [31:0] payload);
        shift_word_u w;
        logic [35:0] bits;
        w.cmd.op      = op;
        w.cmd.payload = payload;
        bits          = w;
        repeat (36) begin
            @(posedge JTCK);
            JCE1   <= 1'b1;
            JSHIFT <= 1'b1;
            JTDI   <= bits[0];
            bits = bits >> 1;
        end
        @(posedge JTCK);
        JCE1    <= 1'b0;
        JSHIFT  <= 1'b0;
        JUPDATE <= 1'b1;
        @(posedge JTCK);
        JUPDATE <= 1'b0;
    endtask

    task automatic capture();
        @(posedge JTCK);
        JCE1   <= 1'b1;
        JSHIFT <= 1'b0;
        JTDI   <= 1'b0;
        @(posedge JTCK);
        JSHIFT <= 1'b1;
        repeat (36) @(posedge JTCK);
        JCE1   <= 1'b0;
        JSHIFT <= 1'b0;
    endtask

    task automatic read_word(input logic [31:0] addr, input logic more);
        int polls;
        polls = 0;
        do begin
            capture();
            polls++;
        end while (!i_chk.has_marker() && polls < POLL_MAX);
        if (i_chk.has_marker()) begin
            i_chk.check_readback(addr, more);
        end else begin
            i_chk.report_error($sformatf("no readback marker after %0d captures", polls));
        end
    endtask

    task automatic read_burst(input burst_t b, input logic decoy);
        send_word(OP_READ, 32'h0);
        for (int k = 0; k <= int'(b.last); k++) begin
            read_word(b.addr + 32'(k), k != int'(b.last));
            // Address change while the read is still pending
            if (decoy && k == 0) begin
                send_word(OP_ADDR, b.addr + 32'd8);
            end
        end
    endtask

    task automatic run_burst(input int t);
        burst_t      b;
        logic [31:0] data;
        b = bursts[t];
        i_chk.set_test(names[t]);
        send_word(OP_ADDR, b.addr);
        send_word(OP_BE, {28'b0, b.be});
        send_word(OP_SIZE, {24'b0, b.last});
        capture();
        i_chk.check_status(CFG_STATUS);
        for (int k = 0; k <= int'(b.last); k++) begin
            data = $random(seed);
            send_word(OP_DATA, data);
            i_chk.note_write(b.addr + 32'(k), b.be, data);
        end
        read_burst(b, b.decoy);
        if (b.decoy) begin
            read_burst(b, 1'b0);
        end
    endtask

    initial begin
        seed    = 32'hf06a0672;
        JRSTN   <= 1'b0;
        JTDI    <= 1'b0;
        JSHIFT  <= 1'b0;
        JUPDATE <= 1'b0;
        JCE1    <= 1'b0;
        repeat (RST_CYC) @(posedge JTCK);
        JRSTN <= 1'b1;
        @(posedge JTCK);
        i_chk.set_test("reset_status");
        capture();
        i_chk.check_status(6'h00);
        for (int t = 0; t < N_BURSTS; t++) begin
            run_burst(t);
        end
        repeat (4) @(posedge JTCK);
        $display("Checks: %0d, errors: %0d, assertion failures: %0d", i_chk.checks,
                 i_chk.errors, i_dut.u_chain.i_sva.fail_cnt);
        if (i_chk.errors == 0 && i_dut.u_chain.i_sva.fail_cnt == 0 && i_chk.checks > 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
hw/jtag_bridge_pkg.sv
hw/jtag_chain.sv
hw/pingpong_buffer.sv
hw/dma_engine.sv
hw/jtag_dma_top.sv
tb/tb_checker.sv
tb/bridge_sva.sv
tb/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the JTAG DMA bridge simulation with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_top -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_top)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
